//--- hdl/degu_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared constants, encodings and decoded-instruction struct, RV32I only
// pc_mask limits fetch and jump targets to a 4 MiB address space
//////////////////////////////////////////////////////////////////////
package degu_pkg;

  // word size
  localparam int unsigned xlen = 32;

  // program counter after reset
  localparam logic [xlen-1:0] rst_vector = 32'h0000_0000;
  // applied to every new program counter
  localparam logic [xlen-1:0] pc_mask = 32'h003f_ffff;

  //////////////////////////////////////////////////////////////////////
  // opcode and funct3 encodings
  //////////////////////////////////////////////////////////////////////

  // major opcode, supported classes plus misc-mem
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_misc   = 7'b0001111
  } opc_t;

  // branch conditions
  typedef enum logic [2:0] {
    bru_beq  = 3'b000,
    bru_bne  = 3'b001,
    bru_blt  = 3'b100,
    bru_bge  = 3'b101,
    bru_bltu = 3'b110,
    bru_bgeu = 3'b111
  } fn3_bru_t;

  // load/store sizes, u variants are zero extended
  typedef enum logic [2:0] {
    ldst_b  = 3'b000,
    ldst_h  = 3'b001,
    ldst_w  = 3'b010,
    ldst_bu = 3'b100,
    ldst_hu = 3'b101
  } fn3_ldst_t;

  // alu operations, alt bit picks sub and sra
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_sr   = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } fn3_alu_t;

  //////////////////////////////////////////////////////////////////////
  // decoded instruction
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    opc_t            opc;
    logic [2:0]      fn3;
    // funct7 bit 30
    logic            alt;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    // register enables
    logic            ren1;
    logic            ren2;
    logic            wen;
    // sign extended immediates
    logic [xlen-1:0] i_i;
    logic [xlen-1:0] i_s;
    logic [xlen-1:0] i_b;
    logic [xlen-1:0] i_u;
    logic [xlen-1:0] i_j;
  } dec_t;

endpackage

//--- hdl/degu_dec.sv
//////////////////////////////////////////////////////////////////////
// combinational RV32I decoder
// unknown opcodes, fence and system decode with all enables low
//////////////////////////////////////////////////////////////////////
module degu_dec (
  input  logic [31:0]     instr,
  output degu_pkg::dec_t  dec
);

  always_comb begin
    // raw fields
    dec.opc  = degu_pkg::opc_t'(instr[6:0]);
    dec.fn3  = instr[14:12];
    dec.alt  = instr[30];
    dec.rs1  = instr[19:15];
    dec.rs2  = instr[24:20];
    dec.rd   = instr[11:7];

    // immediates, sign from bit 31 everywhere
    dec.i_i  = {{20{instr[31]}}, instr[31:20]};
    dec.i_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    dec.i_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                instr[11:8], 1'b0};
    dec.i_u  = {instr[31:12], 12'h000};
    dec.i_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                instr[30:21], 1'b0};

    // register enables per class
    dec.ren1 = 1'b0;
    dec.ren2 = 1'b0;
    dec.wen  = 1'b0;
    case (instr[6:0])
      degu_pkg::opc_lui,
      degu_pkg::opc_auipc,
      degu_pkg::opc_jal: begin
        dec.wen  = 1'b1;
      end
      degu_pkg::opc_jalr,
      degu_pkg::opc_load,
      degu_pkg::opc_op_imm: begin
        dec.ren1 = 1'b1;
        dec.wen  = 1'b1;
      end
      degu_pkg::opc_branch,
      degu_pkg::opc_store: begin
        dec.ren1 = 1'b1;
        dec.ren2 = 1'b1;
      end
      degu_pkg::opc_op: begin
        dec.ren1 = 1'b1;
        dec.ren2 = 1'b1;
        dec.wen  = 1'b1;
      end
      // misc-mem, system and anything else act as nop
      default: begin
        dec.wen  = 1'b0;
      end
    endcase
  end

endmodule

//--- hdl/degu_gpr.sv
//////////////////////////////////////////////////////////////////////
// 2 read / 1 write register file, x0 reads zero
// same-cycle write data is bypassed to both read ports
//////////////////////////////////////////////////////////////////////
module degu_gpr (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [4:0]                rs1_adr,
  input  logic [4:0]                rs2_adr,
  input  logic                      rd_wen,
  input  logic [4:0]                rd_adr,
  input  logic [degu_pkg::xlen-1:0] rd_dat,
  output logic [degu_pkg::xlen-1:0] rs1_dat,
  output logic [degu_pkg::xlen-1:0] rs2_dat
);

  // x1 to x31, no storage for x0
  logic [degu_pkg::xlen-1:0] mem [1:31];

  // write port, x0 writes dropped
  always_ff @(posedge clk) begin
    if (rd_wen && (rd_adr != 5'd0)) begin
      mem[rd_adr] <= rd_dat;
    end
  end

  // reads with bypass, rst forces zero while the core is idle
  always_comb begin
    if (rst || (rs1_adr == 5'd0)) begin
      rs1_dat = '0;
    end else if (rd_wen && (rd_adr == rs1_adr)) begin
      rs1_dat = rd_dat;
    end else begin
      rs1_dat = mem[rs1_adr];
    end
    if (rst || (rs2_adr == 5'd0)) begin
      rs2_dat = '0;
    end else if (rd_wen && (rd_adr == rs2_adr)) begin
      rs2_dat = rd_dat;
    end else begin
      rs2_dat = mem[rs2_adr];
    end
  end

endmodule

//--- hdl/degu_alu.sv
//////////////////////////////////////////////////////////////////////
// integer ALU with a 33-bit add/sub side output
// sum carries branch compares, jump targets and memory addresses
//////////////////////////////////////////////////////////////////////
module degu_alu (
  input  degu_pkg::dec_t            dec,
  input  logic [degu_pkg::xlen-1:0] pc,
  input  logic [degu_pkg::xlen-1:0] rs1,
  input  logic [degu_pkg::xlen-1:0] rs2,
  output logic [degu_pkg::xlen-1:0] rd,
  output logic [degu_pkg::xlen:0]   sum
);

  logic [degu_pkg::xlen-1:0] op1;
  logic [degu_pkg::xlen-1:0] op2;
  logic                      sub;
  logic                      sgn;
  logic [4:0]                sha;

  // operand select
  always_comb begin
    case (dec.opc)
      degu_pkg::opc_auipc: begin
        op1 = pc;
        op2 = dec.i_u;
      end
      degu_pkg::opc_jal: begin
        op1 = pc;
        op2 = dec.i_j;
      end
      degu_pkg::opc_store: begin
        op1 = rs1;
        op2 = dec.i_s;
      end
      degu_pkg::opc_op,
      degu_pkg::opc_branch: begin
        op1 = rs1;
        op2 = rs2;
      end
      // op-imm, load, jalr
      default: begin
        op1 = rs1;
        op2 = dec.i_i;
      end
    endcase
  end

  // subtract for branches, sub, slt and sltu
  always_comb begin
    sub = 1'b0;
    sgn = 1'b0;
    case (dec.opc)
      degu_pkg::opc_branch: begin
        sub = 1'b1;
        sgn = (dec.fn3 == degu_pkg::bru_blt) || (dec.fn3 == degu_pkg::bru_bge);
      end
      degu_pkg::opc_op,
      degu_pkg::opc_op_imm: begin
        sub = (dec.fn3 == degu_pkg::alu_slt) || (dec.fn3 == degu_pkg::alu_sltu) ||
              ((dec.opc == degu_pkg::opc_op) && (dec.fn3 == degu_pkg::alu_add) && dec.alt);
        sgn = (dec.fn3 == degu_pkg::alu_slt);
      end
      default: begin
        sub = 1'b0;
      end
    endcase
  end

  // bit 32 is the less-than flag when subtracting
  assign sum = sub ? ({sgn & op1[31], op1} - {sgn & op2[31], op2})
                   : ({sgn & op1[31], op1} + {sgn & op2[31], op2});

  assign sha = op2[4:0];

  // result
  always_comb begin
    case (degu_pkg::fn3_alu_t'(dec.fn3))
      degu_pkg::alu_sll:  rd = op1 << sha;
      degu_pkg::alu_slt,
      degu_pkg::alu_sltu: rd = {31'd0, sum[32]};
      degu_pkg::alu_xor:  rd = op1 ^ op2;
      degu_pkg::alu_sr:   rd = dec.alt ? $unsigned($signed(op1) >>> sha) : (op1 >> sha);
      degu_pkg::alu_or:   rd = op1 | op2;
      degu_pkg::alu_and:  rd = op1 & op2;
      default:            rd = sum[31:0];
    endcase
    // auipc, loads, stores and jumps only need the sum
    if ((dec.opc != degu_pkg::opc_op) && (dec.opc != degu_pkg::opc_op_imm)) begin
      rd = sum[31:0];
    end
  end

endmodule

//--- hdl/degu_ifu.sv
//////////////////////////////////////////////////////////////////////
// fetch unit, fetch read data must hold until the next fetch transfer
// no fetch is requested while a load or store is in execute
//////////////////////////////////////////////////////////////////////
module degu_ifu (
  input  logic                      clk,
  input  logic                      rst,
  input  degu_pkg::dec_t            dec,
  input  logic [degu_pkg::xlen:0]   sum,
  input  logic                      stall,
  input  logic                      ifu_rdy,
  output logic                      ifu_vld,
  output logic [degu_pkg::xlen-1:0] ifu_adr,
  output logic                      ivld,
  output logic [degu_pkg::xlen-1:0] pc,
  output logic [degu_pkg::xlen-1:0] pc_inc
);

  logic                      run;
  logic                      mem_op;
  logic                      tkn;
  logic [degu_pkg::xlen-1:0] pcn;

  //////////////////////////////////////////////////////////////////////
  // fetch request
  //////////////////////////////////////////////////////////////////////

  // run one cycle after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // loads and stores take the bus first, fetch follows
  assign mem_op  = ivld && ((dec.opc == degu_pkg::opc_load) ||
                            (dec.opc == degu_pkg::opc_store));
  assign ifu_vld = run && !mem_op;
  assign ifu_adr = pcn;

  // instruction valid, held through a stall
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ivld <= 1'b0;
    end else begin
      ivld <= (ifu_vld && ifu_rdy) || (ivld && stall);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // branch and next pc
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (degu_pkg::fn3_bru_t'(dec.fn3))
      degu_pkg::bru_beq:  tkn = ~|sum[31:0];
      degu_pkg::bru_bne:  tkn =  |sum[31:0];
      degu_pkg::bru_blt,
      degu_pkg::bru_bltu: tkn =  sum[32];
      degu_pkg::bru_bge,
      degu_pkg::bru_bgeu: tkn = ~sum[32];
      default:            tkn = 1'b0;
    endcase
  end

  assign pc_inc = pc + 32'd4;

  // without a valid instruction the pc is refetched
  always_comb begin
    if (!ivld) begin
      pcn = pc;
    end else if ((dec.opc == degu_pkg::opc_jal) || (dec.opc == degu_pkg::opc_jalr)) begin
      pcn = {sum[31:1], 1'b0} & degu_pkg::pc_mask;
    end else if ((dec.opc == degu_pkg::opc_branch) && tkn) begin
      pcn = (pc + dec.i_b) & degu_pkg::pc_mask;
    end else begin
      pcn = pc_inc & degu_pkg::pc_mask;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= degu_pkg::rst_vector;
    end else if (ivld && !stall) begin
      pc <= pcn;
    end
  end

endmodule

//--- hdl/degu_lsu.sv
//////////////////////////////////////////////////////////////////////
// load/store unit, aligned accesses only, no misalignment check
// rdt is valid in the cycle after the load transfer
//////////////////////////////////////////////////////////////////////
module degu_lsu (
  input  degu_pkg::dec_t            dec,
  input  logic                      ivld,
  input  logic [degu_pkg::xlen-1:0] adr,
  input  logic [degu_pkg::xlen-1:0] wdt,
  output logic                      lsu_vld,
  output logic                      lsu_wen,
  output logic [degu_pkg::xlen-1:0] lsu_adr,
  output logic [3:0]                lsu_byt,
  output logic [degu_pkg::xlen-1:0] lsu_wdt,
  input  logic [degu_pkg::xlen-1:0] lsu_rdt,
  input  logic                      clk,
  input  logic                      rst,
  output logic [degu_pkg::xlen-1:0] rdt
);

  logic                      ld;
  logic                      st;
  logic [2:0]                ld_fn3;
  logic [1:0]                ld_off;
  logic [degu_pkg::xlen-1:0] shf;

  //////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////

  assign ld      = dec.opc == degu_pkg::opc_load;
  assign st      = dec.opc == degu_pkg::opc_store;
  assign lsu_vld = ivld && (ld || st);
  assign lsu_wen = st;
  assign lsu_adr = adr;

  // byte enables and lane replication
  always_comb begin
    case (dec.fn3[1:0])
      2'b00: begin
        lsu_byt = 4'b0001 << adr[1:0];
        lsu_wdt = {4{wdt[7:0]}};
      end
      2'b01: begin
        lsu_byt = 4'b0011 << {adr[1], 1'b0};
        lsu_wdt = {2{wdt[15:0]}};
      end
      default: begin
        lsu_byt = 4'b1111;
        lsu_wdt = wdt;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // load data alignment
  //////////////////////////////////////////////////////////////////////

  // captured every request cycle, the last one is the transfer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ld_fn3 <= 3'd0;
      ld_off <= 2'd0;
    end else if (lsu_vld) begin
      ld_fn3 <= dec.fn3;
      ld_off <= adr[1:0];
    end
  end

  assign shf = lsu_rdt >> {ld_off, 3'b000};

  always_comb begin
    case (degu_pkg::fn3_ldst_t'(ld_fn3))
      degu_pkg::ldst_b:  rdt = {{24{shf[7]}}, shf[7:0]};
      degu_pkg::ldst_bu: rdt = {24'd0, shf[7:0]};
      degu_pkg::ldst_h:  rdt = {{16{shf[15]}}, shf[15:0]};
      degu_pkg::ldst_hu: rdt = {16'd0, shf[15:0]};
      default:           rdt = lsu_rdt;
    endcase
  end

endmodule

//--- hdl/degu_core.sv
//////////////////////////////////////////////////////////////////////
// RV32I core top, fetch and load/store buses with vld/rdy handshake
// register writes land one cycle after retirement, bypass covers the gap
//////////////////////////////////////////////////////////////////////
module degu_core (
  input  logic                      clk,
  input  logic                      rst,
  // fetch bus
  output logic                      ifu_vld,
  output logic [degu_pkg::xlen-1:0] ifu_adr,
  input  logic                      ifu_rdy,
  input  logic [degu_pkg::xlen-1:0] ifu_rdt,
  // load/store bus
  output logic                      lsu_vld,
  output logic                      lsu_wen,
  output logic [degu_pkg::xlen-1:0] lsu_adr,
  output logic [3:0]                lsu_byt,
  output logic [degu_pkg::xlen-1:0] lsu_wdt,
  input  logic                      lsu_rdy,
  input  logic [degu_pkg::xlen-1:0] lsu_rdt
);

  logic                      stall;
  logic                      ivld;
  logic [degu_pkg::xlen-1:0] pc;
  logic [degu_pkg::xlen-1:0] pc_inc;
  degu_pkg::dec_t            dec;
  logic [degu_pkg::xlen-1:0] rs1_dat;
  logic [degu_pkg::xlen-1:0] rs2_dat;
  logic [degu_pkg::xlen-1:0] alu_rd;
  logic [degu_pkg::xlen:0]   alu_sum;
  logic [degu_pkg::xlen-1:0] ld_dat;
  logic [degu_pkg::xlen-1:0] ex_dat;
  // delayed write-back
  logic                      wb_wen;
  logic                      wb_ld;
  logic [4:0]                wb_adr;
  logic [degu_pkg::xlen-1:0] wb_dat;
  logic [degu_pkg::xlen-1:0] rd_dat;

  // any bus waiting on rdy
  assign stall = (ifu_vld && !ifu_rdy) || (lsu_vld && !lsu_rdy);

  degu_ifu u_ifu (
    .clk     (clk),
    .rst     (rst),
    .dec     (dec),
    .sum     (alu_sum),
    .stall   (stall),
    .ifu_rdy (ifu_rdy),
    .ifu_vld (ifu_vld),
    .ifu_adr (ifu_adr),
    .ivld    (ivld),
    .pc      (pc),
    .pc_inc  (pc_inc)
  );

  degu_dec u_dec (
    .instr (ifu_rdt),
    .dec   (dec)
  );

  // unused read ports look at x0
  degu_gpr u_gpr (
    .clk     (clk),
    .rst     (rst),
    .rs1_adr (dec.ren1 ? dec.rs1 : 5'd0),
    .rs2_adr (dec.ren2 ? dec.rs2 : 5'd0),
    .rd_wen  (wb_wen),
    .rd_adr  (wb_adr),
    .rd_dat  (rd_dat),
    .rs1_dat (rs1_dat),
    .rs2_dat (rs2_dat)
  );

  degu_alu u_alu (
    .dec (dec),
    .pc  (pc),
    .rs1 (rs1_dat),
    .rs2 (rs2_dat),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  degu_lsu u_lsu (
    .dec     (dec),
    .ivld    (ivld),
    .adr     (alu_sum[degu_pkg::xlen-1:0]),
    .wdt     (rs2_dat),
    .lsu_vld (lsu_vld),
    .lsu_wen (lsu_wen),
    .lsu_adr (lsu_adr),
    .lsu_byt (lsu_byt),
    .lsu_wdt (lsu_wdt),
    .lsu_rdt (lsu_rdt),
    .clk     (clk),
    .rst     (rst),
    .rdt     (ld_dat)
  );

  //////////////////////////////////////////////////////////////////////
  // write-back
  //////////////////////////////////////////////////////////////////////

  // execute result select
  always_comb begin
    case (dec.opc)
      degu_pkg::opc_lui:  ex_dat = dec.i_u;
      degu_pkg::opc_jal,
      degu_pkg::opc_jalr: ex_dat = pc_inc;
      default:            ex_dat = alu_rd;
    endcase
  end

  // one write per retired instruction
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_wen <= 1'b0;
      wb_ld  <= 1'b0;
      wb_adr <= 5'd0;
    end else begin
      wb_wen <= ivld && !stall && dec.wen;
      wb_ld  <= dec.opc == degu_pkg::opc_load;
      wb_adr <= dec.rd;
    end
  end

  always_ff @(posedge clk) begin
    wb_dat <= ex_dat;
  end

  // load data arrives in the write-back cycle
  assign rd_dat = wb_ld ? ld_dat : wb_dat;

endmodule

//--- test/degu_props.sv
//////////////////////////////////////////////////////////////////////
// bus handshake and reset checks, bound into degu_core
// fails counts failed assertions, the testbench reads it at the end
//////////////////////////////////////////////////////////////////////
module degu_props (
  input logic                      clk,
  input logic                      rst,
  input logic                      ifu_vld,
  input logic [degu_pkg::xlen-1:0] ifu_adr,
  input logic                      ifu_rdy,
  input logic                      lsu_vld,
  input logic                      lsu_wen,
  input logic [degu_pkg::xlen-1:0] lsu_adr,
  input logic [3:0]                lsu_byt,
  input logic [degu_pkg::xlen-1:0] lsu_wdt,
  input logic                      lsu_rdy
);

  int unsigned fails = 0;

  // fetch request frozen until rdy
  a_ifu_hold: assert property (@(posedge clk) disable iff (rst)
    ifu_vld && !ifu_rdy |=> ifu_vld && $stable(ifu_adr))
    else begin
      $error("fetch request changed while waiting for rdy");
      fails++;
    end

  // every load/store field frozen until rdy
  a_lsu_hold: assert property (@(posedge clk) disable iff (rst)
    lsu_vld && !lsu_rdy |=> lsu_vld && $stable(lsu_wen) && $stable(lsu_adr) &&
                            $stable(lsu_byt) && $stable(lsu_wdt))
    else begin
      $error("load/store request changed while waiting for rdy");
      fails++;
    end

  // quiet buses in reset
  a_rst_idle: assert property (@(posedge clk) rst |-> !ifu_vld && !lsu_vld)
    else begin
      $error("bus request raised during reset");
      fails++;
    end

  a_byt_set: assert property (@(posedge clk) disable iff (rst) lsu_vld |-> lsu_byt != 4'd0)
    else begin
      $error("load/store request with no byte enabled");
      fails++;
    end

endmodule

//--- test/degu_tb_model.svh
//////////////////////////////////////////////////////////////////////
// instruction-set model, runs imem from rst_vector up to the final loop
// mdmem starts as a copy of dmem, so call it after the program is built
//////////////////////////////////////////////////////////////////////
`ifndef DEGU_TB_MODEL_SVH
`define DEGU_TB_MODEL_SVH

// model data memory, same 512 words as the bus model
logic [31:0] mdmem [0:511];

function automatic logic [31:0] alu_result(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
  case (f3)
    3'd0:    return alt ? (a - b) : (a + b);
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
  case (f3)
    3'd0:    return a == b;
    3'd1:    return a != b;
    3'd4:    return $signed(a) < $signed(b);
    3'd5:    return $signed(a) >= $signed(b);
    3'd6:    return a < b;
    3'd7:    return a >= b;
    default: return 1'b0;
  endcase
endfunction

task automatic run_model();
  logic [31:0] x [0:31];
  logic [31:0] pc;
  logic [31:0] npc;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] ea;
  logic [31:0] res;
  logic [31:0] sh;
  logic [2:0]  f3;
  logic [3:0]  byt;
  logic        we;
  int unsigned steps;
  int          lane;
  foreach (x[r]) x[r] = '0;
  foreach (dmem[w]) mdmem[w] = dmem[w];
  pc    = degu_pkg::rst_vector;
  steps = 0;
  while ((pc != loop_adr) && (steps < max_steps)) begin
    ins = imem[pc[10:2]];
    f3  = ins[14:12];
    a   = x[ins[19:15]];
    b   = x[ins[24:20]];
    npc = pc + 32'd4;
    res = '0;
    we  = 1'b1;
    case (ins[6:0])
      degu_pkg::opc_lui:   res = {ins[31:12], 12'h000};
      degu_pkg::opc_auipc: res = pc + {ins[31:12], 12'h000};
      degu_pkg::opc_jal: begin
        res = pc + 32'd4;
        npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      degu_pkg::opc_jalr: begin
        res = pc + 32'd4;
        npc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
      end
      degu_pkg::opc_branch: begin
        we = 1'b0;
        if (branch_taken(f3, a, b)) begin
          npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      degu_pkg::opc_load: begin
        ea = a + {{20{ins[31]}}, ins[31:20]};
        sh = mdmem[ea[10:2]] >> (8 * ea[1:0]);
        case (f3)
          3'd0:    res = {{24{sh[7]}}, sh[7:0]};
          3'd1:    res = {{16{sh[15]}}, sh[15:0]};
          3'd4:    res = {24'd0, sh[7:0]};
          3'd5:    res = {16'd0, sh[15:0]};
          default: res = mdmem[ea[10:2]];
        endcase
      end
      degu_pkg::opc_store: begin
        we = 1'b0;
        ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        // data replicated over all lanes
        case (f3[1:0])
          2'b00: begin
            byt = 4'b0001 << ea[1:0];
            res = {4{b[7:0]}};
          end
          2'b01: begin
            byt = 4'b0011 << ea[1:0];
            res = {2{b[15:0]}};
          end
          default: begin
            byt = 4'b1111;
            res = b;
          end
        endcase
        exp_adr.push_back(ea);
        exp_byt.push_back(byt);
        exp_dat.push_back(res);
        for (lane = 0; lane < 4; lane++) begin
          if (byt[lane]) mdmem[ea[10:2]][8*lane +: 8] = res[8*lane +: 8];
        end
      end
      degu_pkg::opc_op_imm: res = alu_result(f3, (f3 == 3'd5) && ins[30], a,
                                             {{20{ins[31]}}, ins[31:20]});
      degu_pkg::opc_op:     res = alu_result(f3, ins[30], a, b);
      // fence, system and the rest
      default:              we = 1'b0;
    endcase
    if (we && (ins[11:7] != 5'd0)) x[ins[11:7]] = res;
    pc = npc & degu_pkg::pc_mask;
    steps++;
  end
  if (pc != loop_adr) begin
    $display("model ran %0d steps without reaching the final loop", steps);
    errors++;
  end
endtask

`endif

//--- test/degu_tb.sv
//////////////////////////////////////////////////////////////////////
// random RV32I program checked store by store against an ISA model
// separate fetch and data memories of 512 words, rdy about 70 % high
//////////////////////////////////////////////////////////////////////
module degu_tb;

  localparam int unsigned n_body     = 300;
  localparam int unsigned body_end   = 31 + n_body;
  localparam int unsigned max_cycles = 20000;
  localparam int unsigned max_steps  = 5000;

  logic                      clk;
  logic                      rst;
  logic                      ifu_vld;
  logic [degu_pkg::xlen-1:0] ifu_adr;
  logic                      ifu_rdy;
  logic [degu_pkg::xlen-1:0] ifu_rdt;
  logic                      lsu_vld;
  logic                      lsu_wen;
  logic [degu_pkg::xlen-1:0] lsu_adr;
  logic [3:0]                lsu_byt;
  logic [degu_pkg::xlen-1:0] lsu_wdt;
  logic                      lsu_rdy;
  logic [degu_pkg::xlen-1:0] lsu_rdt;

  // program, data and expected stores
  logic [31:0]               imem [0:511];
  logic [31:0]               dmem [0:511];
  logic [31:0]               loop_adr;
  logic [degu_pkg::xlen-1:0] exp_adr [$];
  logic [3:0]                exp_byt [$];
  logic [degu_pkg::xlen-1:0] exp_dat [$];
  int unsigned               errors     = 0;
  int unsigned               n_stores   = 0;
  logic                      first_seen = 1'b0;
  logic                      loop_seen  = 1'b0;

  `include "degu_tb_model.svh"

  degu_core u_dut (.*);

  bind degu_core degu_props u_props (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // instruction encoding and program generation
  //////////////////////////////////////////////////////////////////////

  // also used for R type with imm = {funct7, rs2}
  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // data offset in the 1 KiB region, aligned to the access size
  function automatic logic [11:0] data_offset(logic [2:0] f3);
    logic [11:0] off;
    off = 12'($urandom % 1024);
    if (f3[1:0] == 2'b10) off[1:0] = 2'b00;
    if (f3[1:0] == 2'b01) off[0] = 1'b0;
    return off;
  endfunction

  task automatic gen_program();
    int unsigned i;
    int unsigned k;
    int unsigned r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [31:0] w;
    // nop fill, data words hashed from the whole index
    for (i = 0; i < 512; i++) begin
      imem[i] = 32'h0000_0013;
      dmem[i] = (i * 32'h9e37_79b9) ^ (i << 20) ^ 32'h00c6_c6c6;
    end
    // every register gets a known value first
    for (i = 0; i < 31; i++) begin
      w = $urandom;
      if (i % 2) imem[i] = {w[31:12], 5'(i + 1), 7'b0110111};
      else imem[i] = i_type(w[11:0], 5'd0, 3'd0, 5'(i + 1), 7'b0010011);
    end
    while (i < body_end) begin
      r   = $urandom % 16;
      rd  = 5'($urandom);
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      f3  = 3'($urandom);
      w   = $urandom;
      // forward distance, never past the dump
      k   = 1 + $urandom % 4;
      if (i + k > body_end) k = body_end - i;
      if (r < 5) begin
        imem[i] = i_type({1'b0, w[0] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2},
                         rs1, f3, rd, 7'b0110011);
      end else if (r < 9) begin
        if (f3 == 3'd1) imm = {7'd0, w[4:0]};
        else if (f3 == 3'd5) imm = {1'b0, w[5], 5'd0, w[4:0]};
        else imm = w[11:0];
        imem[i] = i_type(imm, rs1, f3, rd, 7'b0010011);
      end else if (r == 9) begin
        imem[i] = {w[31:12], rd, w[0] ? 7'b0110111 : 7'b0010111};
      end else if (r < 12) begin
        // load, then a use of its result right away
        k  = $urandom % 5;
        f3 = (k < 3) ? 3'(k) : 3'(k + 1);
        imem[i] = i_type(data_offset(f3), 5'd0, f3, rd, 7'b0000011);
        if (i + 1 < body_end) begin
          i++;
          imem[i] = i_type({7'd0, rs2}, rd, 3'd0, rs1, 7'b0110011);
        end
      end else if (r == 12) begin
        f3 = 3'($urandom % 3);
        imem[i] = s_type(data_offset(f3), rs2, f3);
      end else if (r < 15) begin
        r  = $urandom % 6;
        f3 = (r < 2) ? 3'(r) : 3'(r + 2);
        imem[i] = b_type(13'(k * 4), rs2, rs1, f3);
      end else if (w[0]) begin
        imem[i] = j_type(21'(k * 4), rd);
      end else begin
        imem[i] = i_type(12'((i + k) * 4), 5'd0, 3'd0, rd, 7'b1100111);
      end
      i++;
    end
    // register dump at 0x404, then a self-loop
    for (k = 1; k < 32; k++) begin
      imem[i] = s_type(12'(12'h400 + 4 * k), 5'(k), 3'd2);
      i++;
    end
    loop_adr = 32'(i * 4);
    imem[i]  = j_type(21'd0, 5'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(string name, logic [degu_pkg::xlen-1:0] got,
                            logic [degu_pkg::xlen-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_byt(string name, logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_store(logic [degu_pkg::xlen-1:0] adr, logic [3:0] byt,
                             logic [degu_pkg::xlen-1:0] dat);
    if (exp_adr.size() == 0) begin
      $display("store to %h seen after the model ran out of stores", adr);
      errors++;
    end else begin
      check_word("lsu_adr", adr, exp_adr.pop_front());
      check_byt("lsu_byt", byt, exp_byt.pop_front());
      check_word("lsu_wdt", dat, exp_dat.pop_front());
      n_stores++;
    end
  endtask

  task automatic check_fetch(logic [degu_pkg::xlen-1:0] adr);
    check_word("ifu_adr", adr, degu_pkg::rst_vector);
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus memories, sampled mid cycle and driven just after the edge
  //////////////////////////////////////////////////////////////////////

  initial begin : bus_model
    logic                      f_x;
    logic                      l_x;
    logic                      l_w;
    logic [degu_pkg::xlen-1:0] f_a;
    logic [degu_pkg::xlen-1:0] l_a;
    logic [degu_pkg::xlen-1:0] l_d;
    logic [3:0]                l_b;
    int                        lane;
    forever begin
      @(negedge clk);
      if (rst && (ifu_vld || lsu_vld)) begin
        $display("bus request raised during reset at %0t", $time);
        errors++;
      end
      if (!rst && ifu_vld && !first_seen) begin
        check_fetch(ifu_adr);
        first_seen = 1'b1;
      end
      // transfers that complete at the coming edge
      f_x = ifu_vld && ifu_rdy;
      f_a = ifu_adr;
      l_x = lsu_vld && lsu_rdy;
      l_w = lsu_wen;
      l_a = lsu_adr;
      l_b = lsu_byt;
      l_d = lsu_wdt;
      if (f_x && (f_a == loop_adr)) loop_seen = 1'b1;
      if (l_x && l_w) check_store(l_a, l_b, l_d);
      @(posedge clk);
      #1;
      // read data held until the next transfer
      if (f_x) ifu_rdt = imem[f_a[10:2]];
      if (l_x && l_w) begin
        for (lane = 0; lane < 4; lane++) begin
          if (l_b[lane]) dmem[l_a[10:2]][8*lane +: 8] = l_d[8*lane +: 8];
        end
      end
      if (l_x && !l_w) lsu_rdt = dmem[l_a[10:2]];
      ifu_rdy = ($urandom % 10) < 7;
      lsu_rdy = ($urandom % 10) < 7;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned cyc;
    rst     = 1'b1;
    ifu_rdy = 1'b0;
    ifu_rdt = '0;
    lsu_rdy = 1'b0;
    lsu_rdt = '0;
    void'($urandom(32'hc6c6));
    gen_program();
    run_model();
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    // run until the self-loop is fetched with every store seen
    cyc = 0;
    while (!(loop_seen && (exp_adr.size() == 0)) && (cyc < max_cycles)) begin
      @(posedge clk);
      cyc++;
    end
    if (!(loop_seen && (exp_adr.size() == 0))) begin
      $display("timeout after %0d cycles, %0d stores still expected", cyc, exp_adr.size());
      errors++;
    end
    errors += u_dut.u_props.fails;
    $display("errors %0d, stores checked %0d", errors, n_stores);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+test
hdl/degu_pkg.sv
hdl/degu_dec.sv
hdl/degu_gpr.sv
hdl/degu_alu.sv
hdl/degu_ifu.sv
hdl/degu_lsu.sv
hdl/degu_core.sv
test/degu_props.sv
test/degu_tb.sv
